/* design/ex_alu.sv */
/*
 * Integer ALU
 * Single-cycle RV32 add, sub, logic, shift and compare operations
 */

`timescale 1ns/1ps

module ex_alu (
  input  ex_pkg::ex_req_t req_i,
  output ex_pkg::word_t   result_o
);
  import ex_pkg::*;

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign op_a  = req_i.operand_a;
  assign op_b  = req_i.operand_b;

  // Shift amount comes from the low five bits only
  assign shamt = op_b[4:0];

  // Comparators shared by SLT and SLTU
  assign lt_signed   = $signed(op_a) < $signed(op_b);
  assign lt_unsigned = op_a < op_b;

  //////////////////////////////////////////////////////////////////////
  // Operation select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (req_i.op)
      OP_ADD:  result_o = op_a + op_b;
      OP_SUB:  result_o = op_a - op_b;
      OP_AND:  result_o = op_a & op_b;
      OP_OR:   result_o = op_a | op_b;
      OP_XOR:  result_o = op_a ^ op_b;
      OP_SLL:  result_o = op_a << shamt;
      OP_SRL:  result_o = op_a >> shamt;
      // Arithmetic shift keeps the sign bit
      OP_SRA:  result_o = word_t'($signed(op_a) >>> shamt);
      // Compares give a single bit, zero extended
      OP_SLT:  result_o = word_t'(lt_signed);
      OP_SLTU: result_o = word_t'(lt_unsigned);
      // Not an ALU op, output ignored by the commit logic
      default: result_o = '0;
    endcase
  end

endmodule

/* design/ex_commit.sv */
/*
 * Execute stage controller
 * Starts the functional units, holds finished results under
 * back-pressure, and owns the EX/WB register and both handshakes
 */

`timescale 1ns/1ps

module ex_commit (
  input  logic            clk,
  input  logic            rst_n,
  input  ex_pkg::ex_req_t req_i,
  input  logic            req_valid_i,
  output logic            req_ready_o,
  input  logic            flush_i,
  input  ex_pkg::word_t   alu_result_i,
  output logic            mul_start_o,
  input  logic            mul_done_i,
  input  ex_pkg::word_t   mul_result_i,
  output logic            div_start_o,
  output logic            div_abort_o,
  input  logic            div_done_i,
  input  ex_pkg::word_t   div_result_i,
  output ex_pkg::ex_rsp_t rsp_o,
  output logic            rsp_valid_o,
  input  logic            rsp_ready_i
);
  import ex_pkg::*;

  // Room for killed multiplies still draining the pipeline
  localparam int unsigned STALE_W = 4;

  ex_unit_e           unit;
  logic               active;
  logic               wb_free;
  logic               mul_done_own;
  logic               unit_done;
  logic               res_avail;
  logic               wb_load;
  logic               stale_inc;
  logic               stale_dec;
  word_t              unit_result;
  word_t              wb_data;

  logic               started_q;
  logic               held_q;
  word_t              held_res_q;
  logic [STALE_W-1:0] stale_q;
  ex_rsp_t            rsp_q;

  assign unit    = op_unit(req_i.op);
  assign active  = req_valid_i && !flush_i;
  assign wb_free = !rsp_valid_o || rsp_ready_i;

  // A done belongs to the current multiply only once stale ones are out
  assign mul_done_own = mul_done_i && (stale_q == '0);
  assign unit_done    = started_q && (((unit == UNIT_MUL) && mul_done_own) ||
                                      ((unit == UNIT_DIV) && div_done_i));

  always_comb begin
    case (unit)
      UNIT_MUL: unit_result = mul_result_i;
      UNIT_DIV: unit_result = div_result_i;
      default:  unit_result = alu_result_i;
    endcase
  end

  assign wb_data   = held_q ? held_res_q : unit_result;
  assign res_avail = (unit == UNIT_ALU) || held_q || unit_done;
  assign wb_load   = active && res_avail && wb_free;

  // Ready doubles as the completion pulse of the item in EX
  assign req_ready_o = flush_i || wb_load;

  // One start per request
  assign mul_start_o = active && (unit == UNIT_MUL) && !started_q && !held_q;
  assign div_start_o = active && (unit == UNIT_DIV) && !started_q && !held_q;
  assign div_abort_o = flush_i && started_q && (unit == UNIT_DIV);

  // Killed multiply leaves a done pulse to swallow later
  assign stale_inc = flush_i && started_q && (unit == UNIT_MUL) && !mul_done_own;
  assign stale_dec = mul_done_i && (stale_q != '0);

  //////////////////////////////////////////////////////////////////////
  // Request tracking
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      started_q <= 1'b0;
      held_q    <= 1'b0;
      stale_q   <= '0;
    end else begin
      if (req_ready_o || unit_done) begin
        started_q <= 1'b0;
      end else if (mul_start_o || div_start_o) begin
        started_q <= 1'b1;
      end
      // Result parked while EX/WB is blocked
      if (req_ready_o) begin
        held_q <= 1'b0;
      end else if (unit_done) begin
        held_q <= 1'b1;
      end
      stale_q <= stale_q + STALE_W'(stale_inc) - STALE_W'(stale_dec);
    end
  end

  always_ff @(posedge clk) begin
    if (unit_done && !held_q) begin
      held_res_q <= unit_result;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_o <= 1'b0;
    end else if (wb_load) begin
      rsp_valid_o <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_load) begin
      rsp_q.rd     <= req_i.rd;
      rsp_q.result <= wb_data;
    end
  end

  assign rsp_o = rsp_q;

endmodule

/* design/ex_div.sv */
/*
 * Iterative divider
 * Restoring division on operand magnitudes, one quotient bit per
 * cycle, then a sign-fix cycle; handles DIV, DIVU, REM and REMU
 */

`timescale 1ns/1ps

module ex_div (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start_i,
  input  logic            abort_i,
  input  ex_pkg::ex_req_t req_i,
  output logic            done_o,
  output ex_pkg::word_t   result_o
);
  import ex_pkg::*;

  localparam int unsigned CNT_W = $clog2(xlen);

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_FIX
  } div_state_e;

  div_state_e       state_q;
  logic [CNT_W-1:0] cnt_q;
  logic             busy;

  // Operand decode at start
  logic             is_signed;
  logic             a_neg;
  logic             b_neg;
  word_t            a_mag;
  word_t            b_mag;

  // Iteration registers and latched op info
  word_t            quo_q;
  word_t            rem_q;
  word_t            dvs_q;
  logic             is_rem_q;
  logic             neg_quo_q;
  logic             neg_rem_q;

  logic [xlen:0]    shifted;
  logic [xlen:0]    diff;
  word_t            fixed;

  assign busy = (state_q != DIV_IDLE);

  assign is_signed = (req_i.op == OP_DIV) || (req_i.op == OP_REM);
  assign a_neg     = is_signed & req_i.operand_a[xlen-1];
  assign b_neg     = is_signed & req_i.operand_b[xlen-1];
  assign a_mag     = a_neg ? -req_i.operand_a : req_i.operand_a;
  assign b_mag     = b_neg ? -req_i.operand_b : req_i.operand_b;

  // Trial subtract of the divisor from the shifted partial remainder
  assign shifted = {rem_q, quo_q[xlen-1]};
  assign diff    = shifted - {1'b0, dvs_q};

  // Remainder follows the dividend sign, quotient the sign of a xor b
  always_comb begin
    if (is_rem_q) begin
      fixed = neg_rem_q ? -rem_q : rem_q;
    end else begin
      fixed = neg_quo_q ? -quo_q : quo_q;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
      done_o  <= 1'b0;
    end else begin
      done_o <= (state_q == DIV_FIX) && !abort_i;
      if (abort_i) begin
        // Drop whatever is running, no done pulse
        state_q <= DIV_IDLE;
      end else begin
        case (state_q)
          DIV_IDLE: begin
            if (start_i) begin
              state_q <= DIV_RUN;
              cnt_q   <= '0;
            end
          end
          DIV_RUN: begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CNT_W'(xlen - 1)) begin
              state_q <= DIV_FIX;
            end
          end
          default: state_q <= DIV_IDLE;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (start_i && !busy) begin
      quo_q     <= a_mag;
      rem_q     <= '0;
      dvs_q     <= b_mag;
      is_rem_q  <= (req_i.op == OP_REM) || (req_i.op == OP_REMU);
      // Divide by zero keeps the all-ones quotient unsigned
      neg_quo_q <= (a_neg ^ b_neg) && (req_i.operand_b != '0);
      neg_rem_q <= a_neg;
    end else if (state_q == DIV_RUN) begin
      if (!diff[xlen]) begin
        rem_q <= diff[xlen-1:0];
        quo_q <= {quo_q[xlen-2:0], 1'b1};
      end else begin
        rem_q <= shifted[xlen-1:0];
        quo_q <= {quo_q[xlen-2:0], 1'b0};
      end
    end
    if (state_q == DIV_FIX) begin
      result_o <= fixed;
    end
  end

endmodule

/* design/ex_mult.sv */
/*
 * Pipelined 32x32 multiplier
 * Forms the full product and returns the low or high word after a
 * fixed number of register stages; accepts a new start every cycle
 */

`timescale 1ns/1ps

module ex_mult #(
  parameter int unsigned MUL_STAGES = 2
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start_i,
  input  ex_pkg::ex_req_t req_i,
  output logic            done_o,
  output ex_pkg::word_t   result_o
);
  import ex_pkg::*;

  logic               a_signed;
  logic               b_signed;
  logic signed [xlen:0]     a_ext;
  logic signed [xlen:0]     b_ext;
  logic signed [2*xlen+1:0] prod_full;
  logic                     want_hi;

  // Per-stage valid, word select and product
  logic [MUL_STAGES-1:0]    vld_q;
  logic [MUL_STAGES-1:0]    hi_q;
  logic [2*xlen-1:0]        prod_q [MUL_STAGES];

  // Operand signedness per opcode
  assign a_signed = (req_i.op == OP_MULH) || (req_i.op == OP_MULHSU);
  assign b_signed = (req_i.op == OP_MULH);

  // One extra bit so unsigned operands stay positive
  assign a_ext = {a_signed & req_i.operand_a[xlen-1], req_i.operand_a};
  assign b_ext = {b_signed & req_i.operand_b[xlen-1], req_i.operand_b};

  assign prod_full = a_ext * b_ext;
  assign want_hi   = (req_i.op != OP_MUL);

  //////////////////////////////////////////////////////////////////////
  // Pipeline registers
  //////////////////////////////////////////////////////////////////////

  // Valid bit travels alongside the product
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= start_i;
      for (int i = 1; i < MUL_STAGES; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    prod_q[0] <= prod_full[2*xlen-1:0];
    hi_q[0]   <= want_hi;
    for (int i = 1; i < MUL_STAGES; i++) begin
      prod_q[i] <= prod_q[i-1];
      hi_q[i]   <= hi_q[i-1];
    end
  end

  // Last stage drives the outputs
  assign done_o   = vld_q[MUL_STAGES-1];
  assign result_o = hi_q[MUL_STAGES-1] ? prod_q[MUL_STAGES-1][2*xlen-1:xlen]
                                       : prod_q[MUL_STAGES-1][xlen-1:0];

endmodule

/* design/ex_pkg.sv */
/*
 * Execute stage shared definitions
 * Word and tag types, opcode and unit enums, request and response
 * structs, and the mapping from opcode to functional unit
 */

package ex_pkg;

  // Data path width
  localparam int unsigned xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  // Operations executed in EX, grouped by functional unit
  typedef enum logic [4:0] {
    // ALU group
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
    // Multiplier group
    OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
    // Divider group
    OP_DIV, OP_DIVU, OP_REM, OP_REMU
  } ex_op_e;

  typedef enum logic [1:0] {
    UNIT_ALU,
    UNIT_MUL,
    UNIT_DIV
  } ex_unit_e;

  // Request from decode, 74 bits
  typedef struct packed {
    ex_op_e    op;
    word_t     operand_a;
    word_t     operand_b;
    reg_addr_t rd;
  } ex_req_t;

  // Entry of the EX/WB register, 37 bits
  typedef struct packed {
    reg_addr_t rd;
    word_t     result;
  } ex_rsp_t;

  // Which unit runs a given opcode
  function automatic ex_unit_e op_unit(input ex_op_e op);
    case (op)
      OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU: return UNIT_MUL;
      OP_DIV, OP_DIVU, OP_REM, OP_REMU:     return UNIT_DIV;
      default:                              return UNIT_ALU;
    endcase
  endfunction

endpackage

/* design/ex_stage.sv */
/*
 * Execute stage top
 * Connects the ALU, multiplier, divider and the stage controller
 */

`timescale 1ns/1ps

module ex_stage #(
  parameter int unsigned MUL_STAGES = 2
) (
  input  logic            clk,
  input  logic            rst_n,
  input  ex_pkg::ex_req_t req_i,
  input  logic            req_valid_i,
  output logic            req_ready_o,
  input  logic            flush_i,
  output ex_pkg::ex_rsp_t rsp_o,
  output logic            rsp_valid_o,
  input  logic            rsp_ready_i
);
  import ex_pkg::*;

  // Unit results
  word_t alu_result;
  word_t mul_result;
  word_t div_result;

  // Unit control
  logic  mul_start;
  logic  mul_done;
  logic  div_start;
  logic  div_abort;
  logic  div_done;

  ex_alu alu_i (
    .req_i    (req_i),
    .result_o (alu_result)
  );

  ex_mult #(
    .MUL_STAGES (MUL_STAGES)
  ) mult_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_i  (mul_start),
    .req_i    (req_i),
    .done_o   (mul_done),
    .result_o (mul_result)
  );

  ex_div div_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_i  (div_start),
    .abort_i  (div_abort),
    .req_i    (req_i),
    .done_o   (div_done),
    .result_o (div_result)
  );

  ex_commit commit_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .flush_i      (flush_i),
    .alu_result_i (alu_result),
    .mul_start_o  (mul_start),
    .mul_done_i   (mul_done),
    .mul_result_i (mul_result),
    .div_start_o  (div_start),
    .div_abort_o  (div_abort),
    .div_done_i   (div_done),
    .div_result_i (div_result),
    .rsp_o        (rsp_o),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i)
  );

endmodule

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ex_stage -f tb.f -o sim_ex_stage

sim_status=0
./obj_dir/sim_ex_stage +verilator+error+limit+1000 > sim.log 2>&1 || sim_status=$?
cat sim.log

if [ "$sim_status" -ne 0 ] || grep -q "Testbench failed" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation ok"

/* tb.f */
+incdir+verification
design/ex_pkg.sv
design/ex_alu.sv
design/ex_mult.sv
design/ex_div.sv
design/ex_commit.sv
design/ex_stage.sv
verification/ex_stage_assert.sv
verification/tb_ex_stage.sv

/* verification/ex_stage_assert.sv */
/*
 * Execute stage handshake assertions
 * Bound into the stage top; checks the EX/WB stall hold, quiet
 * outputs in reset and exclusive unit starts
 */

`timescale 1ns/1ps

module ex_stage_assert (
  input logic            clk,
  input logic            rst_n,
  input logic            rsp_valid_o,
  input logic            rsp_ready_i,
  input ex_pkg::ex_rsp_t rsp_o,
  input logic            mul_start,
  input logic            div_start
);

  // Failures seen so far, read by the testbench at the end
  int fail_cnt = 0;

  // EX/WB entry holds while write-back stalls
  assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
  else begin
    fail_cnt++;
    $error("EX/WB register changed while write-back was stalled");
  end

  // Nothing leaves the stage during reset
  assert property (@(posedge clk) !rst_n |-> !rsp_valid_o && !mul_start && !div_start)
  else begin
    fail_cnt++;
    $error("output or unit start active during reset");
  end

  // Only one unit runs a request
  assert property (@(posedge clk) disable iff (!rst_n) !(mul_start && div_start))
  else begin
    fail_cnt++;
    $error("multiplier and divider started together");
  end

endmodule

bind ex_stage ex_stage_assert assert_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .rsp_valid_o (rsp_valid_o),
  .rsp_ready_i (rsp_ready_i),
  .rsp_o       (rsp_o),
  .mul_start   (mul_start),
  .div_start   (div_start)
);

/* verification/ex_ref_model.svh */
/*
 * Execute stage reference model
 * Expected result of each opcode, written from the RV32I and
 * M-extension rules, including divide by zero and signed overflow
 */

`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// Upper word of a 64-bit product, operands extended as requested
function automatic word_t mul_upper(input word_t a, input word_t b,
                                    input bit a_sgn, input bit b_sgn);
  logic [63:0] ax;
  logic [63:0] bx;
  logic [63:0] prod;
  ax   = a_sgn ? {{32{a[31]}}, a} : {32'b0, a};
  bx   = b_sgn ? {{32{b[31]}}, b} : {32'b0, b};
  // Low 64 bits of the wrapped product equal the exact product
  prod = ax * bx;
  return prod[63:32];
endfunction

// Divide and remainder with the RISC-V special cases
function automatic word_t div_ref(input ex_op_e op, input word_t a, input word_t b);
  int  sa;
  int  sb;
  bit  ovf;
  sa  = a;
  sb  = b;
  ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
  case (op)
    OP_DIV:  return (b == 0) ? 32'hffff_ffff : (ovf ? a : word_t'(sa / sb));
    OP_REM:  return (b == 0) ? a : (ovf ? 32'd0 : word_t'(sa % sb));
    OP_DIVU: return (b == 0) ? 32'hffff_ffff : a / b;
    default: return (b == 0) ? a : a % b;
  endcase
endfunction

// Expected write-back value for any opcode
function automatic word_t expect_result(input ex_op_e op, input word_t a, input word_t b);
  int sa;
  int sb;
  sa = a;
  sb = b;
  case (op)
    OP_ADD:    return a + b;
    OP_SUB:    return a - b;
    OP_AND:    return a & b;
    OP_OR:     return a | b;
    OP_XOR:    return a ^ b;
    OP_SLL:    return a << b[4:0];
    OP_SRL:    return a >> b[4:0];
    OP_SRA:    return word_t'(sa >>> b[4:0]);
    OP_SLT:    return (sa < sb) ? 32'd1 : 32'd0;
    OP_SLTU:   return (a < b) ? 32'd1 : 32'd0;
    OP_MUL:    return a * b;
    OP_MULH:   return mul_upper(a, b, 1'b1, 1'b1);
    OP_MULHSU: return mul_upper(a, b, 1'b1, 1'b0);
    OP_MULHU:  return mul_upper(a, b, 1'b0, 1'b0);
    default:   return div_ref(op, a, b);
  endcase
endfunction

`endif

/* verification/tb_ex_stage.sv */
/*
 * Execute stage testbench
 * Random requests, write-back stalls and flush pulses, with a
 * scoreboard against the reference model and a run watchdog
 */

`timescale 1ns/1ps

module tb_ex_stage;
  import ex_pkg::*;

  `include "ex_ref_model.svh"

  localparam int CLK_PERIOD = 4;
  localparam int DRIVE_DLY  = 1;
  localparam int MUL_STAGES = 2;
  // Cycles allowed for one handshake or for a drain
  localparam int HS_LIMIT   = 200;
  // Operations per test
  localparam int N_ALU      = 200;
  localparam int N_MD       = 150;
  localparam int N_DIR      = 20;
  localparam int N_BP       = 150;
  localparam int N_FL       = 150;
  localparam int N_MIX      = 300;
  localparam int TOTAL_OPS  = N_ALU + N_MD + N_DIR + N_BP + N_FL + N_MIX;
  localparam int WATCHDOG_NS = (TOTAL_OPS * (xlen + 10) + 2000) * CLK_PERIOD;

  logic    clk;
  logic    rst_n;
  ex_req_t req_i;
  logic    req_valid_i;
  logic    req_ready_o;
  logic    flush_i;
  ex_rsp_t rsp_o;
  logic    rsp_valid_o;
  logic    rsp_ready_i;

  integer  seed;
  integer  stall_seed;
  int      ready_percent;
  ex_rsp_t exp_q[$];
  ex_rsp_t exp_rsp;
  ex_rsp_t new_rsp;
  int      errors;
  int      acc_cnt;
  int      flush_cnt;
  int      rsp_cnt;
  int      test_cnt;

  ex_stage #(
    .MUL_STAGES (MUL_STAGES)
  ) ex_stage_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .flush_i     (flush_i),
    .rsp_o       (rsp_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Hard limit on the whole run
  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired at time %0t, the run did not finish", $time);
    $display("Testbench failed");
    $finish;
  end

  // Write-back ready drawn each cycle at the current rate
  initial begin
    rsp_ready_i = 1'b0;
    forever begin
      @(posedge clk);
      #(DRIVE_DLY);
      rsp_ready_i = ({$random(stall_seed)} % 100) < ready_percent;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Scoreboard sampled mid-cycle where all signals are settled
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      // Pop before push since the entry in EX/WB is older
      if (rsp_valid_o && rsp_ready_i) begin
        rsp_cnt++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("ERROR: time %0t: response for rd %0d with no request outstanding",
                   $time, rsp_o.rd);
        end else begin
          exp_rsp = exp_q.pop_front();
          if (rsp_o.rd != exp_rsp.rd || rsp_o.result != exp_rsp.result) begin
            errors++;
            $display("MISMATCH time %0t: rd %0d result %h, expected rd %0d result %h",
                     $time, rsp_o.rd, rsp_o.result, exp_rsp.rd, exp_rsp.result);
          end
        end
      end
      // A flush always consumes the presented request
      if (flush_i && !req_ready_o) begin
        errors++;
        $display("ERROR: time %0t: flush did not consume the presented request for rd %0d",
                 $time, req_i.rd);
      end
      // Flushed requests are consumed without a result
      if (req_valid_i && req_ready_o) begin
        if (flush_i) begin
          flush_cnt++;
        end else begin
          acc_cnt++;
          new_rsp.rd     = req_i.rd;
          new_rsp.result = expect_result(req_i.op, req_i.operand_a, req_i.operand_b);
          exp_q.push_back(new_rsp);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // Kind 0 gives ALU ops and kind 1 multiply and divide ops, any other kind all opcodes
  function automatic ex_op_e pick_op(input int kind);
    int r;
    case (kind)
      0:       r = {$random(seed)} % 10;
      1:       r = 10 + {$random(seed)} % 8;
      default: r = {$random(seed)} % 18;
    endcase
    return ex_op_e'(r[4:0]);
  endfunction

  // Corner values mixed into random operands
  function automatic word_t rand_operand();
    int sel;
    sel = {$random(seed)} % 8;
    case (sel)
      0:       return 32'd0;
      1:       return 32'hffff_ffff;
      2:       return 32'h8000_0000;
      3:       return word_t'({$random(seed)} % 16);
      default: return $random(seed);
    endcase
  endfunction

  // Directed divide cases with zero divisor and overflow among them
  function automatic ex_req_t div_case(input int op_idx, input int pair);
    ex_req_t r;
    case (op_idx)
      0:       r.op = OP_DIV;
      1:       r.op = OP_DIVU;
      2:       r.op = OP_REM;
      default: r.op = OP_REMU;
    endcase
    // Dividend of each pair
    case (pair)
      0:       r.operand_a = 32'h1234_5678;
      1:       r.operand_a = 32'h8000_0000;
      2:       r.operand_a = 32'd0;
      3:       r.operand_a = 32'hffff_fff9;
      default: r.operand_a = 32'd7;
    endcase
    // Divisor of each pair
    case (pair)
      0:       r.operand_b = 32'd0;
      1:       r.operand_b = 32'hffff_ffff;
      2:       r.operand_b = 32'd0;
      3:       r.operand_b = 32'd2;
      default: r.operand_b = 32'hffff_fffe;
    endcase
    r.rd = 5'(op_idx * 5 + pair);
    return r;
  endfunction

  // Present one request after a gap and hold it until ready
  task automatic send_req(input ex_req_t r, input int gap, input int flush_at);
    int  waited;
    bit  done;
    repeat (gap) begin
      @(posedge clk);
      #(DRIVE_DLY);
    end
    req_i       = r;
    req_valid_i = 1'b1;
    waited      = 0;
    done        = 1'b0;
    while (!done) begin
      // One-cycle kill at the chosen wait count
      flush_i = (waited == flush_at);
      @(negedge clk);
      if (req_ready_o) begin
        done = 1'b1;
      end else if (waited >= HS_LIMIT) begin
        errors++;
        $display("ERROR: time %0t: request for rd %0d not accepted after %0d cycles",
                 $time, r.rd, waited);
        done = 1'b1;
      end
      @(posedge clk);
      #(DRIVE_DLY);
      waited++;
    end
    req_valid_i = 1'b0;
    flush_i     = 1'b0;
  endtask

  // Wait until every expected result has left the stage
  task automatic drain_pipe(input string name);
    int cyc;
    cyc = 0;
    while ((exp_q.size() != 0 || rsp_valid_o) && cyc < HS_LIMIT) begin
      @(posedge clk);
      #(DRIVE_DLY);
      cyc++;
    end
    if (exp_q.size() != 0 || rsp_valid_o) begin
      errors++;
      $display("ERROR: test %s: %0d results never came out of the stage",
               name, exp_q.size());
      exp_q.delete();
    end
  endtask

  task automatic run_test(input string name, input int n, input int kind,
                          input int ready_pct, input int flush_pct,
                          input int max_gap, input bit directed);
    ex_req_t r;
    int      acc0;
    int      flu0;
    int      rsp0;
    int      err0;
    int      roll;
    int      flush_at;
    acc0 = acc_cnt;
    flu0 = flush_cnt;
    rsp0 = rsp_cnt;
    err0 = errors;
    ready_percent = ready_pct;
    if (directed) begin
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 5; j++) begin
          send_req(div_case(i, j), 0, -1);
        end
      end
    end
    for (int i = 0; i < n; i++) begin
      r.op        = pick_op(kind);
      r.operand_a = rand_operand();
      r.operand_b = rand_operand();
      r.rd        = 5'($random(seed));
      flush_at    = -1;
      roll        = {$random(seed)} % 100;
      // Kill point spread over a whole divide and kept early for other ops
      if (roll < flush_pct) begin
        if (op_unit(r.op) == UNIT_DIV) begin
          flush_at = {$random(seed)} % (xlen + 4);
        end else begin
          flush_at = {$random(seed)} % (MUL_STAGES + 2);
        end
      end
      send_req(r, {$random(seed)} % (max_gap + 1), flush_at);
    end
    drain_pipe(name);
    if (rsp_cnt - rsp0 != acc_cnt - acc0) begin
      errors++;
      $display("ERROR: test %s: %0d responses for %0d unflushed requests",
               name, rsp_cnt - rsp0, acc_cnt - acc0);
    end
    test_cnt++;
    $display("test %s: %0d accepted, %0d flushed, %0d responses, %0d errors",
             name, acc_cnt - acc0, flush_cnt - flu0, rsp_cnt - rsp0, errors - err0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed          = 32'h2087;
    // Second stream for stall patterns
    stall_seed    = 32'h2087 + 1;
    ready_percent = 100;
    errors        = 0;
    acc_cnt       = 0;
    flush_cnt     = 0;
    rsp_cnt       = 0;
    test_cnt      = 0;
    req_i         = '0;
    req_valid_i   = 1'b0;
    flush_i       = 1'b0;
    rst_n         = 1'b0;
    repeat (2) @(posedge clk);
    #(DRIVE_DLY);
    rst_n = 1'b1;

    run_test("alu", N_ALU, 0, 100, 0, 1, 1'b0);
    run_test("mul_div", N_MD, 1, 100, 0, 1, 1'b1);
    run_test("backpressure", N_BP, 2, 40, 0, 2, 1'b0);
    run_test("flush", N_FL, 2, 70, 30, 2, 1'b0);
    run_test("mixed", N_MIX, 2, 60, 0, 3, 1'b0);

    errors = errors + ex_stage_i.assert_i.fail_cnt;
    $display("summary: %0d tests, %0d accepted, %0d flushed, %0d responses, %0d errors",
             test_cnt, acc_cnt, flush_cnt, rsp_cnt, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
